/* logic/lsb_pkg.sv */
package lsb_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;

  typedef enum logic [1:0] {
    SZ_BYTE,
    SZ_HALF,
    SZ_WORD,
    SZ_NONE
  } mem_size_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } txn_state_e;

  typedef struct packed {
    addr_t     addr;
    logic      store;
    mem_size_e size;
    word_t     data;
    logic      sign;   // Loads only
  } pipe_req_t;

  typedef struct packed {
    addr_t     addr;
    logic      store;
    mem_size_e size;
    word_t     data;   // Low lanes
  } mem_req_t;

  // ==============================
  // Byte mask helpers
  // ==============================

  function automatic be_t size_to_mask(input logic [1:0] offset, input mem_size_e size);
    case (size)
      SZ_BYTE: return be_t'(4'b0001 << offset);
      SZ_HALF: return offset[1] ? 4'b1100 : 4'b0011;
      SZ_WORD: return 4'b1111;
      default: return 4'b0000;
    endcase
  endfunction

  function automatic word_t place_data(input word_t data, input logic [1:0] offset,
                                       input mem_size_e size);
    word_t w;
    w = '0;
    case (size)
      SZ_BYTE: w[offset*8 +: 8] = data[7:0];
      SZ_HALF: w[offset[1]*16 +: 16] = data[15:0];
      SZ_WORD: w = data;
      default: w = '0;
    endcase
    return w;
  endfunction

  function automatic mem_size_e mask_to_size(input be_t mask);
    case (mask)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: return SZ_BYTE;
      4'b0011, 4'b1100: return SZ_HALF;
      4'b1111: return SZ_WORD;
      default: return SZ_NONE;
    endcase
  endfunction

  function automatic logic mask_encodable(input be_t mask);
    return mask_to_size(mask) != SZ_NONE;
  endfunction

  function automatic logic [1:0] mask_to_offset(input be_t mask);
    case (mask)
      4'b0010: return 2'd1;
      4'b0100, 4'b1100: return 2'd2;
      4'b1000: return 2'd3;
      default: return 2'd0;
    endcase
  endfunction

endpackage

/* logic/lsb_queue_ptrs.sv */
`timescale 1ns/1ps

module lsb_queue_ptrs #(
  parameter int unsigned DEPTH = 4,
  localparam int unsigned PTR_W = $clog2(DEPTH),
  localparam int unsigned CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  logic             pop_i,
  output logic [PTR_W-1:0] head_o,
  output logic [PTR_W-1:0] tail_o,
  output logic [PTR_W-1:0] last_o,
  output logic [CNT_W-1:0] count_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam logic [PTR_W-1:0] PTR_MAX = PTR_W'(DEPTH - 1);

  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_MAX) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        tail_q <= ptr_inc(tail_q);
      end
      if (pop_i) begin
        head_q <= ptr_inc(head_q);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign head_o  = head_q;
  assign tail_o  = tail_q;
  assign last_o  = (tail_q == '0) ? PTR_MAX : tail_q - 1'b1;  // Newest entry
  assign count_o = count_q;
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));

  // FSM must hold back stores and pops on these edges
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

/* logic/lsb_store_queue.sv */
`timescale 1ns/1ps

module lsb_store_queue #(
  parameter int unsigned DEPTH = 4,
  localparam int unsigned PTR_W = $clog2(DEPTH),
  localparam int unsigned CNT_W = $clog2(DEPTH + 1)
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  lsb_pkg::pipe_req_t req_i,
  input  logic               push_i,
  input  logic               busy_head_i,
  input  logic [PTR_W-1:0]   head_i,
  input  logic [PTR_W-1:0]   tail_i,
  input  logic [PTR_W-1:0]   last_i,
  input  logic [CNT_W-1:0]   count_i,
  output logic               merge_o,
  output logic               fwd_hit_o,
  output lsb_pkg::word_t     fwd_word_o,
  output lsb_pkg::mem_req_t  head_req_o
);

  import lsb_pkg::*;

  localparam logic [PTR_W-1:0] PTR_MAX = PTR_W'(DEPTH - 1);

  addr_t word_addr_q [DEPTH];
  word_t data_q      [DEPTH];   // Bytes outside the mask stay zero
  be_t   mask_q      [DEPTH];

  addr_t            req_word_addr;
  be_t              req_mask;
  word_t            req_data;
  be_t              merged_mask;
  word_t            merged_data;
  be_t              fwd_mask;
  logic [PTR_W-1:0] scan_ptr;
  logic [1:0]       head_offset;

  assign req_word_addr = {req_i.addr[31:2], 2'b00};
  assign req_mask      = size_to_mask(req_i.addr[1:0], req_i.size);
  assign req_data      = place_data(req_i.data, req_i.addr[1:0], req_i.size);

  // ==============================
  // Tail merge
  // ==============================
  assign merged_mask = mask_q[last_i] | req_mask;

  always_comb begin
    merged_data = data_q[last_i];
    for (int b = 0; b < 4; b++) begin
      if (req_mask[b]) begin
        merged_data[b*8 +: 8] = req_data[b*8 +: 8];
      end
    end
  end

  // Never touch the entry that memory is busy with
  assign merge_o = req_i.store && (count_i != '0) &&
                   (word_addr_q[last_i] == req_word_addr) &&
                   mask_encodable(merged_mask) &&
                   !(busy_head_i && (last_i == head_i));

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      if (merge_o) begin
        data_q[last_i] <= merged_data;
        mask_q[last_i] <= merged_mask;
      end else begin
        word_addr_q[tail_i] <= req_word_addr;
        data_q[tail_i]      <= req_data;
        mask_q[tail_i]      <= req_mask;
      end
    end
  end

  // ==============================
  // Forwarding, newest first
  // ==============================
  always_comb begin
    fwd_word_o = '0;
    fwd_mask   = '0;
    scan_ptr   = last_i;
    for (int k = 0; k < int'(DEPTH); k++) begin
      if (k < int'(count_i)) begin
        if (word_addr_q[scan_ptr] == req_word_addr) begin
          for (int b = 0; b < 4; b++) begin
            if (mask_q[scan_ptr][b] && !fwd_mask[b]) begin
              fwd_word_o[b*8 +: 8] = data_q[scan_ptr][b*8 +: 8];
            end
          end
          fwd_mask = fwd_mask | mask_q[scan_ptr];
        end
        scan_ptr = (scan_ptr == '0) ? PTR_MAX : scan_ptr - 1'b1;
      end
    end
  end

  assign fwd_hit_o = !req_i.store && (req_mask != '0) && ((fwd_mask & req_mask) == req_mask);

  // Head entry as a memory write, data shifted down to lane 0
  assign head_offset      = mask_to_offset(mask_q[head_i]);
  assign head_req_o.addr  = word_addr_q[head_i] | addr_t'(head_offset);
  assign head_req_o.store = 1'b1;
  assign head_req_o.size  = mask_to_size(mask_q[head_i]);
  assign head_req_o.data  = data_q[head_i] >> (head_offset * 8);

  a_head_encodable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_i != '0) |-> mask_encodable(mask_q[head_i]));

endmodule

/* logic/lsb_txn_fsm.sv */
`timescale 1ns/1ps

module lsb_txn_fsm (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  input  lsb_pkg::pipe_req_t req_i,
  input  logic               merge_i,
  input  logic               fwd_hit_i,
  input  logic               empty_i,
  input  logic               full_i,
  input  lsb_pkg::mem_req_t  head_req_i,
  input  logic               mem_req_ready_i,
  input  logic               mem_rsp_valid_i,
  output logic               req_ready_o,
  output logic               push_o,
  output logic               pop_o,
  output logic               busy_head_o,
  output logic               mem_req_valid_o,
  output lsb_pkg::mem_req_t  mem_req_o,
  output logic               ld_valid_o,
  output logic               ld_from_mem_o,
  output lsb_pkg::addr_t     ld_addr_o,
  output lsb_pkg::mem_size_e ld_size_o,
  output logic               ld_sign_o
);

  import lsb_pkg::*;

  txn_state_e state_q;
  txn_state_e state_d;
  mem_req_t   txn_q;
  logic       is_load_q;
  logic       sign_q;
  logic       store_ok;
  logic       rsp_load;
  logic       issue_head;
  logic       issue_load;

  assign store_ok   = !full_i || merge_i;
  assign rsp_load   = (state_q == ST_WAIT) && is_load_q && mem_rsp_valid_i;
  assign issue_head = (state_q == ST_IDLE) && !empty_i;          // Drain first
  assign issue_load = (state_q == ST_IDLE) && empty_i && req_valid_i &&
                      !req_i.store && !fwd_hit_i;

  // Loads that miss the queue are taken when their data returns
  assign req_ready_o     = req_i.store ? store_ok : (fwd_hit_i || rsp_load);
  assign push_o          = req_valid_i && req_i.store && store_ok;
  assign pop_o           = (state_q == ST_WAIT) && !is_load_q && mem_rsp_valid_i;
  assign busy_head_o     = issue_head ||
                           ((state_q != ST_IDLE) && !is_load_q);  // Head latched or in flight
  assign mem_req_valid_o = (state_q == ST_REQ);
  assign mem_req_o       = txn_q;
  assign ld_valid_o      = (req_valid_i && !req_i.store && fwd_hit_i) || rsp_load;
  assign ld_from_mem_o   = (state_q == ST_WAIT) && is_load_q;
  assign ld_addr_o       = txn_q.addr;
  assign ld_size_o       = txn_q.size;
  assign ld_sign_o       = sign_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (issue_head || issue_load) state_d = ST_REQ;
      ST_REQ:  if (mem_req_ready_i) state_d = ST_WAIT;
      ST_WAIT: if (mem_rsp_valid_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      is_load_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (issue_head) begin
        is_load_q <= 1'b0;
      end else if (issue_load) begin
        is_load_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_head) begin
      txn_q <= head_req_i;
    end else if (issue_load) begin
      txn_q  <= '{addr: req_i.addr, store: 1'b0, size: req_i.size, data: '0};
      sign_q <= req_i.sign;
    end
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

/* logic/lsb_load_align.sv */
`timescale 1ns/1ps

module lsb_load_align (
  input  lsb_pkg::word_t     word_i,     // Lane-aligned word
  input  logic [1:0]         offset_i,
  input  lsb_pkg::mem_size_e size_i,
  input  logic               sign_i,
  output lsb_pkg::word_t     data_o
);

  import lsb_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  assign sel_byte = word_i[offset_i*8 +: 8];
  assign sel_half = word_i[offset_i[1]*16 +: 16];

  always_comb begin
    case (size_i)
      SZ_BYTE: data_o = {{24{sign_i & sel_byte[7]}}, sel_byte};
      SZ_HALF: data_o = {{16{sign_i & sel_half[15]}}, sel_half};
      SZ_WORD: data_o = word_i;
      default: data_o = '0;
    endcase
  end

endmodule

/* logic/lsb_top.sv */
`timescale 1ns/1ps

module lsb_top #(
  parameter int unsigned DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  input  lsb_pkg::pipe_req_t req_i,
  output logic               req_ready_o,
  output logic               ld_valid_o,
  output lsb_pkg::word_t     ld_data_o,
  output logic               mem_req_valid_o,
  output lsb_pkg::mem_req_t  mem_req_o,
  input  logic               mem_req_ready_i,
  input  logic               mem_rsp_valid_i,
  input  lsb_pkg::word_t     mem_rsp_data_i
);

  import lsb_pkg::*;

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] last;
  logic [CNT_W-1:0] count;
  logic             empty;
  logic             full;
  logic             push;
  logic             pop;
  logic             alloc;
  logic             merge;
  logic             busy_head;
  logic             fwd_hit;
  logic             ld_from_mem;
  logic             ld_sign;
  word_t            fwd_word;
  mem_req_t         head_req;
  addr_t            ld_addr;
  mem_size_e        ld_size;

  // A merge reuses the newest entry, so the tail stays put
  assign alloc = push & ~merge;

  lsb_queue_ptrs #(
    .DEPTH (DEPTH)
  ) i_ptrs (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (alloc),
    .pop_i   (pop),
    .head_o  (head),
    .tail_o  (tail),
    .last_o  (last),
    .count_o (count),
    .empty_o (empty),
    .full_o  (full)
  );

  lsb_store_queue #(
    .DEPTH (DEPTH)
  ) i_queue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .push_i      (push),
    .busy_head_i (busy_head),
    .head_i      (head),
    .tail_i      (tail),
    .last_i      (last),
    .count_i     (count),
    .merge_o     (merge),
    .fwd_hit_o   (fwd_hit),
    .fwd_word_o  (fwd_word),
    .head_req_o  (head_req)
  );

  lsb_txn_fsm i_fsm (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .merge_i         (merge),
    .fwd_hit_i       (fwd_hit),
    .empty_i         (empty),
    .full_i          (full),
    .head_req_i      (head_req),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .req_ready_o     (req_ready_o),
    .push_o          (push),
    .pop_o           (pop),
    .busy_head_o     (busy_head),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .ld_valid_o      (ld_valid_o),
    .ld_from_mem_o   (ld_from_mem),
    .ld_addr_o       (ld_addr),
    .ld_size_o       (ld_size),
    .ld_sign_o       (ld_sign)
  );

  // Forwarded loads use the live request, memory loads the latched one
  lsb_load_align i_align (
    .word_i   (ld_from_mem ? mem_rsp_data_i : fwd_word),
    .offset_i (ld_from_mem ? ld_addr[1:0] : req_i.addr[1:0]),
    .size_i   (ld_from_mem ? ld_size : req_i.size),
    .sign_i   (ld_from_mem ? ld_sign : req_i.sign),
    .data_o   (ld_data_o)
  );

endmodule

/* sim/lsb_mem_model.sv */
`timescale 1ns/1ps

module lsb_mem_model (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              hold_i,
  input  logic              req_valid_i,
  input  lsb_pkg::mem_req_t req_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output lsb_pkg::word_t    rsp_data_o
);

  import lsb_pkg::*;

  logic [7:0] mem [256];
  int         seed = 91660;
  logic       busy;
  int         delay;
  int         nbytes;
  word_t      rd_word;
  logic       ready_nxt;
  logic       rsp_nxt;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'h9c;
    end
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    rd_word     = '0;
    busy        = 1'b0;
    delay       = 0;
  end

  // Decide at the falling edge, drive just after the rising edge
  always begin
    @(negedge clk_i);
    rsp_nxt = 1'b0;
    if (!rst_n_i) begin
      busy = 1'b0;
    end else if (rsp_valid_o) begin
      busy = 1'b0;                        // Response taken at this edge
    end else if (req_valid_i && req_ready_o) begin
      busy  = 1'b1;
      delay = $unsigned($random(seed)) % 4;
      case (req_i.size)
        SZ_BYTE: nbytes = 1;
        SZ_HALF: nbytes = 2;
        default: nbytes = 4;
      endcase
      if (req_i.store) begin
        for (int b = 0; b < nbytes; b++) begin
          mem[int'(req_i.addr[7:0]) + b] = req_i.data[b*8 +: 8];
        end
      end else begin
        for (int b = 0; b < 4; b++) begin
          rd_word[b*8 +: 8] = mem[int'({req_i.addr[7:2], 2'b00}) + b];
        end
      end
    end else if (busy) begin
      if (delay == 0) begin
        rsp_nxt = 1'b1;
      end else begin
        delay--;
      end
    end
    ready_nxt = rst_n_i && !busy && !hold_i && (($random(seed) % 4) != 0);
    @(posedge clk_i);
    #1;
    req_ready_o = ready_nxt;
    rsp_valid_o = rsp_nxt;
    rsp_data_o  = rd_word;
  end

endmodule

/* sim/lsb_tb.sv */
`timescale 1ns/1ps

module lsb_tb;

  import lsb_pkg::*;

  localparam int DEPTH = 4;

  typedef struct packed {
    logic       store;
    addr_t      addr;
    mem_size_e  size;
    word_t      data;
    logic       sign;
    logic       at_once;   // Taken in its first valid cycle
    logic [7:0] hold;      // Memory held not ready for this many cycles
  } op_t;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  pipe_req_t req;
  logic      req_ready;
  logic      ld_valid;
  word_t     ld_data;
  logic      mem_req_valid;
  mem_req_t  mem_req;
  logic      mem_req_ready;
  logic      mem_rsp_valid;
  word_t     mem_rsp_data;
  logic      hold;

  op_t        ops [$];
  mem_req_t   exp_wr [$];
  mem_req_t   wr_log [$];
  logic [7:0] shadow [256];
  int         hold_left;
  int         rd_count;
  int         exp_reads;
  int         cycles;
  int         limit;

  lsb_top #(
    .DEPTH (DEPTH)
  ) i_dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .req_ready_o     (req_ready),
    .ld_valid_o      (ld_valid),
    .ld_data_o       (ld_data),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_req_ready_i (mem_req_ready),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_data_i  (mem_rsp_data)
  );

  lsb_mem_model i_mem (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .hold_i      (hold),
    .req_valid_i (mem_req_valid),
    .req_i       (mem_req),
    .req_ready_o (mem_req_ready),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_data_o  (mem_rsp_data)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("** FAIL **");
      $fatal(1, "Run stopped by timeout");
    end
  end

  // Log memory traffic before the accepting edge
  always @(negedge clk) begin
    if (rst_n && mem_req_valid && mem_req_ready) begin
      if (mem_req.store) begin
        wr_log.push_back(mem_req);
      end else begin
        rd_count++;
      end
    end
  end

  // ==============================
  // Helpers
  // ==============================

  task automatic check_eq(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "Stopped on the first mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (hold_left > 0) begin
      hold_left--;
    end
    hold = (hold_left > 0);
  endtask

  function automatic int size_bytes(input mem_size_e size);
    case (size)
      SZ_BYTE: return 1;
      SZ_HALF: return 2;
      default: return 4;
    endcase
  endfunction

  function automatic word_t lane_mask(input mem_size_e size);
    case (size)
      SZ_BYTE: return 32'h0000_00ff;
      SZ_HALF: return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  task automatic write_shadow(input addr_t addr, input mem_size_e size, input word_t data);
    for (int b = 0; b < size_bytes(size); b++) begin
      shadow[int'(addr[7:0]) + b] = data[b*8 +: 8];
    end
  endtask

  function automatic word_t expect_load(input addr_t addr, input mem_size_e size,
                                        input logic sign);
    int    base;
    word_t w;
    base = int'(addr[7:0]);
    case (size)
      SZ_BYTE: w = {{24{sign & shadow[base][7]}}, shadow[base]};
      SZ_HALF: w = {{16{sign & shadow[base+1][7]}}, shadow[base+1], shadow[base]};
      default: w = {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
    endcase
    return w;
  endfunction

  task automatic add_op(input logic store, input addr_t addr, input mem_size_e size,
                        input word_t data, input logic sign, input logic at_once,
                        input int hold_cycles);
    ops.push_back('{store: store, addr: addr, size: size, data: data, sign: sign,
                    at_once: at_once, hold: 8'(hold_cycles)});
  endtask

  task automatic add_wr(input addr_t addr, input mem_size_e size, input word_t data);
    exp_wr.push_back('{addr: addr, store: 1'b1, size: size, data: data});
  endtask

  task automatic apply_op(input op_t op);
    int    waited;
    word_t expected;
    waited = 0;
    if (op.hold != 0) begin
      hold_left = op.hold;
      hold      = 1'b1;
    end
    req       = '{addr: op.addr, store: op.store, size: op.size, data: op.data, sign: op.sign};
    req_valid = 1'b1;
    @(negedge clk);
    while (!req_ready) begin
      check_eq("ld_valid_o", word_t'(ld_valid), 0);
      next_cycle();
      waited++;
      @(negedge clk);
    end
    check_eq("req_ready_o in first cycle", word_t'(waited == 0), word_t'(op.at_once));
    if (op.store) begin
      check_eq("ld_valid_o", word_t'(ld_valid), 0);
      write_shadow(op.addr, op.size, op.data);
    end else begin
      expected = expect_load(op.addr, op.size, op.sign);
      check_eq("ld_valid_o", word_t'(ld_valid), 1);
      check_eq("ld_data_o", ld_data, expected);
    end
    next_cycle();
  endtask

  // ==============================
  // Stimulus table
  // ==============================

  task automatic build_table();
    // Plain stores, then loads after the drain
    add_op(1, 'h10, SZ_WORD, 'h8123_4567, 0, 1, 0);
    add_op(1, 'h22, SZ_HALF, 'habcd_f00d, 0, 1, 0);
    add_op(1, 'h31, SZ_BYTE, 'h1234_56c3, 0, 1, 0);
    add_op(0, 'h40, SZ_WORD, 0, 0, 0, 0);
    add_op(0, 'h22, SZ_HALF, 0, 1, 0, 0);
    add_op(0, 'h22, SZ_HALF, 0, 0, 0, 0);
    add_op(0, 'h31, SZ_BYTE, 0, 1, 0, 0);
    add_op(0, 'h31, SZ_BYTE, 0, 0, 0, 0);
    add_op(0, 'h10, SZ_WORD, 0, 0, 0, 0);
    add_op(0, 'h13, SZ_BYTE, 0, 1, 0, 0);
    add_op(0, 'h30, SZ_HALF, 0, 1, 0, 0);
    // Second byte arrives while the first one is being issued
    add_op(1, 'hb0, SZ_BYTE, 'h5a, 0, 1, 0);
    add_op(1, 'hb1, SZ_BYTE, 'h6b, 0, 1, 0);
    add_op(0, 'hb0, SZ_WORD, 0, 0, 0, 0);
    // B in flight, A merges, then forwarding and a partial hit
    add_op(1, 'h50, SZ_WORD, 'h0bad_f00d, 0, 1, 24);
    add_op(1, 'h60, SZ_BYTE, 'h11, 0, 1, 0);
    add_op(1, 'h61, SZ_BYTE, 'h22, 0, 1, 0);
    add_op(1, 'h62, SZ_HALF, 'h4433, 0, 1, 0);
    add_op(0, 'h60, SZ_WORD, 0, 0, 1, 0);
    add_op(1, 'h52, SZ_HALF, 'h7788, 0, 1, 0);
    add_op(0, 'h50, SZ_WORD, 0, 0, 1, 0);
    add_op(1, 'h71, SZ_BYTE, 'ha5, 0, 1, 0);
    add_op(0, 'h70, SZ_HALF, 0, 1, 0, 0);
    // Full queue under back-pressure
    add_op(1, 'h80, SZ_WORD, 'hcafe_0001, 0, 1, 30);
    add_op(1, 'h84, SZ_WORD, 'hcafe_0002, 0, 1, 0);
    add_op(1, 'h88, SZ_WORD, 'hcafe_0003, 0, 1, 0);
    add_op(1, 'h8c, SZ_WORD, 'hcafe_0004, 0, 1, 0);
    add_op(1, 'h90, SZ_WORD, 'hcafe_0005, 0, 0, 0);
    add_op(0, 'ha3, SZ_BYTE, 0, 1, 0, 0);

    add_wr('h10, SZ_WORD, 'h8123_4567);
    add_wr('h22, SZ_HALF, 'h0000_f00d);
    add_wr('h31, SZ_BYTE, 'h0000_00c3);
    add_wr('hb0, SZ_BYTE, 'h0000_005a);
    add_wr('hb1, SZ_BYTE, 'h0000_006b);
    add_wr('h50, SZ_WORD, 'h0bad_f00d);
    add_wr('h60, SZ_WORD, 'h4433_2211);   // One merged write
    add_wr('h52, SZ_HALF, 'h0000_7788);
    add_wr('h71, SZ_BYTE, 'h0000_00a5);
    add_wr('h80, SZ_WORD, 'hcafe_0001);
    add_wr('h84, SZ_WORD, 'hcafe_0002);
    add_wr('h88, SZ_WORD, 'hcafe_0003);
    add_wr('h8c, SZ_WORD, 'hcafe_0004);
    add_wr('h90, SZ_WORD, 'hcafe_0005);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    hold      = 1'b0;
    hold_left = 0;
    rd_count  = 0;
    exp_reads = 0;
    cycles    = 0;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = 8'(i) ^ 8'h9c;
    end
    build_table();
    limit = ops.size() * 40;

    repeat (4) next_cycle();
    rst_n = 1'b1;
    next_cycle();
    @(negedge clk);
    check_eq("mem_req_valid_o", word_t'(mem_req_valid), 0);
    check_eq("ld_valid_o", word_t'(ld_valid), 0);
    next_cycle();

    foreach (ops[i]) begin
      apply_op(ops[i]);
      if (!ops[i].store && !ops[i].at_once) begin
        exp_reads++;
      end
    end
    req_valid = 1'b0;

    check_eq("memory write count", wr_log.size(), exp_wr.size());
    foreach (exp_wr[i]) begin
      check_eq("mem_req_o.addr", wr_log[i].addr, exp_wr[i].addr);
      check_eq("mem_req_o.size", word_t'(wr_log[i].size), word_t'(exp_wr[i].size));
      check_eq("mem_req_o.data", wr_log[i].data & lane_mask(exp_wr[i].size),
               exp_wr[i].data & lane_mask(exp_wr[i].size));
    end
    check_eq("memory read count", rd_count, exp_reads);

    $display("** PASS **");
    $finish;
  end

endmodule

/* lsb.f */
logic/lsb_pkg.sv
logic/lsb_queue_ptrs.sv
logic/lsb_store_queue.sv
logic/lsb_txn_fsm.sv
logic/lsb_load_align.sv
logic/lsb_top.sv
sim/lsb_mem_model.sv
sim/lsb_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsb_tb
FILELIST  ?= lsb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
